// ==== include/hazard_cfg.svh ====
// Hazard block sizing macros, pulled in by the shared package and the multiplier
`ifndef HAZARD_CFG_SVH
`define HAZARD_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file indexing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define HAZ_REG_W 5             // 32 architectural registers

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath and multiplier
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define HAZ_DATA_W 32           // Operand width

// One multiplier bit retired per cycle
`define HAZ_MUL_CYCLES `HAZ_DATA_W

`endif

// ==== logic/hazardPkg.sv ====
// Shared stage, control and encoding types for the hazard block and its testbench
`default_nettype none

`include "hazard_cfg.svh"

package hazardPkg;

    typedef logic [`HAZ_REG_W-1:0]    regIdxT;
    typedef logic [`HAZ_DATA_W-1:0]   dataT;
    typedef logic [2*`HAZ_DATA_W-1:0] productT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        wbAlu   = 3'd0,
        wbPc    = 3'd1,
        wbMulLo = 3'd2,
        wbLoad  = 3'd3,         // Load word
        wbNone  = 3'd4
    } wbSrcT;

    typedef enum logic [1:0] {
        brNone = 2'd0,
        brEq   = 2'd1,
        brNe   = 2'd2,
        brReg  = 2'd3           // Jump register
    } branchT;

    typedef enum logic [1:0] {
        fwdReg = 2'b00,         // Register file value
        fwdWb  = 2'b01,
        fwdMem = 2'b10
    } fwdSelT;

    typedef enum logic {
        mulIdle = 1'b0,
        mulBusy = 1'b1
    } mulStateT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stage register views
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        regIdxT rsD;
        regIdxT rtD;
        branchT branchD;
    } decStageT;

    typedef struct packed {
        regIdxT rsE;
        regIdxT rtE;
        regIdxT writeRegE;
        logic   regWriteE;
        wbSrcT  wbSrcE;
        logic   mulStartE;      // Multiply instruction in execute
    } exeStageT;

    typedef struct packed {
        regIdxT writeRegM;
        logic   regWriteM;
        wbSrcT  wbSrcM;
    } memStageT;

    typedef struct packed {
        regIdxT writeRegW;
        logic   regWriteW;
    } wbStageT;

    // Control outputs
    typedef struct packed {
        logic   forwardAD;
        logic   forwardBD;
        fwdSelT forwardAE;
        fwdSelT forwardBE;
    } fwdCtrlT;

    typedef struct packed {
        logic stallF;
        logic stallD;
        logic flushE;
    } pipeCtrlT;

endpackage

`default_nettype wire

// ==== logic/forwardUnit.sv ====
// Forwarding select logic for the decode and execute operands, purely combinational
`default_nettype none

module forwardUnit
(
    input  hazardPkg::decStageT decStage,
    input  hazardPkg::exeStageT exeStage,
    input  hazardPkg::memStageT memStage,
    input  hazardPkg::wbStageT  wbStage,
    output hazardPkg::fwdCtrlT  fwdCtrl
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Match helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic memHit
    (
        input hazardPkg::regIdxT src,
        input hazardPkg::memStageT m
    );
        return (src != '0) && m.regWriteM && (src == m.writeRegM);
    endfunction

    function automatic logic wbHit
    (
        input hazardPkg::regIdxT src,
        input hazardPkg::wbStageT w
    );
        return (src != '0) && w.regWriteW && (src == w.writeRegW);
    endfunction

    // Memory stage holds the younger result, so it wins
    function automatic hazardPkg::fwdSelT exeSel
    (
        input hazardPkg::regIdxT src,
        input hazardPkg::memStageT m,
        input hazardPkg::wbStageT w
    );
        hazardPkg::fwdSelT sel;
        if (memHit(src, m))
            sel = hazardPkg::fwdMem;
        else if (wbHit(src, w))
            sel = hazardPkg::fwdWb;
        else
            sel = hazardPkg::fwdReg;
        return sel;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Selects
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        fwdCtrl.forwardAE = exeSel(exeStage.rsE, memStage, wbStage);
        fwdCtrl.forwardBE = exeSel(exeStage.rtE, memStage, wbStage);
        fwdCtrl.forwardAD = memHit(decStage.rsD, memStage);  // Branch compare operands
        fwdCtrl.forwardBD = memHit(decStage.rtD, memStage);

        // r0 always reads from the register file
        if (exeStage.rsE == '0)
            assert (fwdCtrl.forwardAE == hazardPkg::fwdReg)
                else $error("forwardUnit: rsE is r0 but forwardAE selects a bypass");
        if (exeStage.rtE == '0)
            assert (fwdCtrl.forwardBE == hazardPkg::fwdReg)
                else $error("forwardUnit: rtE is r0 but forwardBE selects a bypass");
    end

endmodule

`default_nettype wire

// ==== logic/stallUnit.sv ====
// Load-use, branch and multiply hazard detection driving the fetch/decode stall and execute flush
`default_nettype none

module stallUnit
(
    input  logic                clk,
    input  logic                arstN,
    input  hazardPkg::decStageT decStage,
    input  hazardPkg::exeStageT exeStage,
    input  hazardPkg::memStageT memStage,
    input  logic                productValid,
    output logic                mulStart,
    output hazardPkg::pipeCtrlT pipeCtrl
);

    hazardPkg::mulStateT mulState;
    logic                exeMatch;      // Execute destination feeds a decode source
    logic                memMatch;
    logic                loadUse;
    logic                branchStall;
    logic                mulStall;
    logic                anyStall;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data hazards
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign exeMatch = (exeStage.writeRegE != '0) &&
                      ((exeStage.writeRegE == decStage.rsD) ||
                       (exeStage.writeRegE == decStage.rtD));

    assign memMatch = (memStage.writeRegM != '0) &&
                      ((memStage.writeRegM == decStage.rsD) ||
                       (memStage.writeRegM == decStage.rtD));

    // Load result not ready until after memory
    assign loadUse = (exeStage.wbSrcE == hazardPkg::wbLoad) && exeMatch;

    // Branch resolves in decode, so it needs its operands one stage early
    assign branchStall = (decStage.branchD != hazardPkg::brNone) &&
                         ((exeStage.regWriteE && exeMatch) ||
                          ((memStage.wbSrcM == hazardPkg::wbLoad) && memMatch));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Multiply tracking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign mulStart = (mulState == hazardPkg::mulIdle) && exeStage.mulStartE;

    assign mulStall = mulStart ||
                      ((mulState == hazardPkg::mulBusy) && !productValid);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            mulState <= hazardPkg::mulIdle;
        end
        else
        begin
            case (mulState)
                hazardPkg::mulIdle:
                begin
                    if (exeStage.mulStartE)
                        mulState <= hazardPkg::mulBusy;
                end
                hazardPkg::mulBusy:
                begin
                    if (productValid)       // New starts ignored until here
                        mulState <= hazardPkg::mulIdle;
                end
                default:
                begin
                    mulState <= hazardPkg::mulIdle;
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pipeline control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign anyStall = loadUse || branchStall || mulStall;

    // Freeze F and D, bubble into E
    assign pipeCtrl = '{stallF: anyStall, stallD: anyStall, flushE: anyStall};

    // A bubble in E without a held D would drop the instruction
    assert property (@(posedge clk) disable iff (!arstN)
                     pipeCtrl.flushE |-> (pipeCtrl.stallD && pipeCtrl.stallF))
        else $error("stallUnit: flushE without stallD");

    assert property (@(posedge clk) disable iff (!arstN)
                     (mulState == hazardPkg::mulBusy) |-> !mulStart)
        else $error("stallUnit: mulStart while multiplier busy");

endmodule

`default_nettype wire

// ==== logic/seqMultiplier.sv ====
// Iterative shift-add 32x32 unsigned multiplier, one operand bit per cycle, pulses on completion
`default_nettype none

`include "hazard_cfg.svh"

module seqMultiplier
(
    input  logic                       clk,
    input  logic                       arstN,
    input  logic                       mulStart,
    input  logic [`HAZ_DATA_W-1:0]     mulA,
    input  logic [`HAZ_DATA_W-1:0]     mulB,
    output logic [2*`HAZ_DATA_W-1:0]   product,
    output logic                       productValid
);

    localparam int CntW = $clog2(`HAZ_MUL_CYCLES + 1);

    logic [2*`HAZ_DATA_W-1:0] mcand;        // Multiplicand, shifted left each step
    logic [`HAZ_DATA_W-1:0]   mplier;       // Multiplier, shifted right each step
    logic [2*`HAZ_DATA_W-1:0] acc;
    logic [2*`HAZ_DATA_W-1:0] accNext;
    logic [CntW-1:0]          count;        // Steps remaining
    logic                     busy;
    logic                     lastStep;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Step arithmetic
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign accNext  = mplier[0] ? (acc + mcand) : acc;
    assign lastStep = busy && (count == CntW'(1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            busy         <= 1'b0;
            count        <= '0;
            productValid <= 1'b0;
        end
        else
        begin
            productValid <= lastStep;       // One-cycle pulse
            if (mulStart)
            begin
                busy  <= 1'b1;
                count <= CntW'(`HAZ_MUL_CYCLES);
            end
            else if (busy)
            begin
                count <= count - CntW'(1);
                if (lastStep)
                    busy <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (mulStart)
        begin
            mcand  <= {{`HAZ_DATA_W{1'b0}}, mulA};
            mplier <= mulB;
            acc    <= '0;
        end
        else if (busy)
        begin
            acc    <= accNext;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            // Result stays put until the next start
            if (lastStep)
                product <= accNext;
        end
    end

    // Counter must reload before another pulse can follow
    assert property (@(posedge clk) disable iff (!arstN)
                     productValid |=> !productValid)
        else $error("seqMultiplier: productValid held for two cycles");

endmodule

`default_nettype wire

// ==== logic/hazardTop.sv ====
// Hazard control top level; stage registers in, forwarding selects, stalls and multiply result out
`default_nettype none

module hazardTop
(
    input  logic                clk,
    input  logic                arstN,
    input  hazardPkg::decStageT decStage,
    input  hazardPkg::exeStageT exeStage,
    input  hazardPkg::memStageT memStage,
    input  hazardPkg::wbStageT  wbStage,
    input  hazardPkg::dataT     mulA,       // Multiply operands from execute
    input  hazardPkg::dataT     mulB,
    output hazardPkg::fwdCtrlT  fwdCtrl,
    output hazardPkg::pipeCtrlT pipeCtrl,
    output hazardPkg::productT   product,
    output logic                productValid
);

    logic mulStart;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bypass selects
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    forwardUnit u_forwardUnit
    (
        .decStage (decStage),
        .exeStage (exeStage),
        .memStage (memStage),
        .wbStage  (wbStage),
        .fwdCtrl  (fwdCtrl)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stall and flush
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    stallUnit u_stallUnit
    (
        .clk          (clk),
        .arstN        (arstN),
        .decStage     (decStage),
        .exeStage     (exeStage),
        .memStage     (memStage),
        .productValid (productValid),   // Ends the multiply stall
        .mulStart     (mulStart),
        .pipeCtrl     (pipeCtrl)
    );

    // Multiply unit
    seqMultiplier u_seqMultiplier
    (
        .clk          (clk),
        .arstN        (arstN),
        .mulStart     (mulStart),
        .mulA         (mulA),
        .mulB         (mulB),
        .product      (product),
        .productValid (productValid)
    );

endmodule

`default_nettype wire

// ==== bench/tbHazard.sv ====
// Random-stimulus testbench for hazardTop; a model here predicts forwarding, stalls and products
`default_nettype none

`include "hazard_cfg.svh"

module tbHazard;

    localparam int ClkPeriod   = 8;
    localparam int ResetCycles = 10;
    localparam int FwdVectors  = 400;
    localparam int LoadVectors = 400;
    localparam int BrVectors   = 400;
    localparam int MulVectors  = 1600;
    localparam int NumVectors  = FwdVectors + LoadVectors + BrVectors + MulVectors;
    localparam int CycleLimit  = NumVectors * (`HAZ_MUL_CYCLES + 2) + 1000;

    // Stimulus flavours
    localparam int ModeFwd    = 0;
    localparam int ModeLoad   = 1;
    localparam int ModeBranch = 2;
    localparam int ModeMul    = 3;
    localparam int ModeDrain  = 4;     // Multiply traffic without new starts

    logic                clk;
    logic                arstN;
    hazardPkg::decStageT decStage;
    hazardPkg::exeStageT exeStage;
    hazardPkg::memStageT memStage;
    hazardPkg::wbStageT  wbStage;
    hazardPkg::dataT     mulA;
    hazardPkg::dataT     mulB;
    hazardPkg::fwdCtrlT  fwdCtrl;
    hazardPkg::pipeCtrlT pipeCtrl;
    hazardPkg::productT  product;
    logic                productValid;

    // Model of the multiply tracking
    hazardPkg::mulStateT modelState;
    int                  mulAge;       // Cycles since the start edge
    hazardPkg::productT  expProduct;
    hazardPkg::productT  lastProduct;
    logic                haveProduct;
    int                  stallRun;
    int                  startCount;
    int                  pulseCount;

    int errCount;
    int checkCount;
    int testCount;
    int cycleCount;

    hazardTop u_hazardTop
    (
        .clk          (clk),
        .arstN        (arstN),
        .decStage     (decStage),
        .exeStage     (exeStage),
        .memStage     (memStage),
        .wbStage      (wbStage),
        .mulA         (mulA),
        .mulB         (mulB),
        .fwdCtrl      (fwdCtrl),
        .pipeCtrl     (pipeCtrl),
        .product      (product),
        .productValid (productValid)
    );

    initial
    begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount > CycleLimit)
        begin
            $display("Timeout: simulation ran past %0d cycles", CycleLimit);
            $display("Done: errors found");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random picks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic hazardPkg::regIdxT pickReg();
        return hazardPkg::regIdxT'($urandom % 4);  // r0..r3 so matches are frequent
    endfunction

    function automatic hazardPkg::wbSrcT pickWbSrc();
        return hazardPkg::wbSrcT'(3'($urandom % 5));
    endfunction

    function automatic hazardPkg::dataT pickOperand();
        hazardPkg::dataT v;
        case ($urandom % 4)
            0:       v = '0;
            1:       v = '1;
            default: v = hazardPkg::dataT'($urandom);
        endcase
        return v;
    endfunction

    task automatic driveStages(input int mode);
        hazardPkg::decStageT d;
        hazardPkg::exeStageT e;
        hazardPkg::memStageT m;
        hazardPkg::wbStageT  w;

        d.rsD       = pickReg();
        d.rtD       = pickReg();
        d.branchD   = hazardPkg::branchT'(2'($urandom % 4));
        e.rsE       = pickReg();
        e.rtE       = pickReg();
        e.writeRegE = pickReg();
        e.regWriteE = 1'($urandom % 2);
        e.wbSrcE    = pickWbSrc();
        e.mulStartE = 1'b0;
        m.writeRegM = pickReg();
        m.regWriteM = 1'($urandom % 2);
        m.wbSrcM    = pickWbSrc();
        w.writeRegW = pickReg();
        w.regWriteW = 1'($urandom % 2);

        case (mode)
            ModeLoad:
            begin
                d.branchD = hazardPkg::brNone;
                if ($urandom % 2 == 0)
                    e.wbSrcE = hazardPkg::wbLoad;
            end
            ModeBranch:
            begin
                if ($urandom % 4 != 0)
                    d.branchD = hazardPkg::branchT'(2'(1 + $urandom % 3));
                if ($urandom % 2 == 0)
                    m.wbSrcM = hazardPkg::wbLoad;
            end
            ModeMul, ModeDrain:
            begin
                // Keep other hazards out so the stall is the multiply's alone
                d.branchD = hazardPkg::brNone;
                if (e.wbSrcE == hazardPkg::wbLoad)
                    e.wbSrcE = hazardPkg::wbMulLo;
                e.mulStartE = (mode == ModeMul) && ($urandom % 4 == 0);
                mulA = pickOperand();
                mulB = pickOperand();
            end
            default:
            begin
            end
        endcase

        decStage = d;
        exeStage = e;
        memStage = m;
        wbStage  = w;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic memWrites(input hazardPkg::regIdxT src);
        return (src != '0) && memStage.regWriteM && (memStage.writeRegM == src);
    endfunction

    function automatic hazardPkg::fwdSelT exeSelect(input hazardPkg::regIdxT src);
        if (memWrites(src))
            return hazardPkg::fwdMem;
        if ((src != '0) && wbStage.regWriteW && (wbStage.writeRegW == src))
            return hazardPkg::fwdWb;
        return hazardPkg::fwdReg;
    endfunction

    task automatic reportMismatch(input string what, input logic [63:0] got,
                                  input logic [63:0] exp);
        $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        errCount++;
    endtask

    task automatic checkCycle();
        hazardPkg::fwdCtrlT  expFwd;
        hazardPkg::pipeCtrlT expPipe;
        logic                exeHit;
        logic                memLoadHit;
        logic                loadUse;
        logic                branchStall;
        logic                startNow;
        logic                expPv;
        logic                anyStall;

        expFwd.forwardAE = exeSelect(exeStage.rsE);
        expFwd.forwardBE = exeSelect(exeStage.rtE);
        expFwd.forwardAD = memWrites(decStage.rsD);
        expFwd.forwardBD = memWrites(decStage.rtD);

        exeHit = (exeStage.writeRegE != '0) &&
                 ((exeStage.writeRegE == decStage.rsD) || (exeStage.writeRegE == decStage.rtD));
        memLoadHit = (memStage.wbSrcM == hazardPkg::wbLoad) && (memStage.writeRegM != '0) &&
                     ((memStage.writeRegM == decStage.rsD) ||
                      (memStage.writeRegM == decStage.rtD));
        loadUse     = (exeStage.wbSrcE == hazardPkg::wbLoad) && exeHit;
        branchStall = (decStage.branchD != hazardPkg::brNone) &&
                      ((exeStage.regWriteE && exeHit) || memLoadHit);

        startNow = (modelState == hazardPkg::mulIdle) && exeStage.mulStartE;
        expPv    = (modelState == hazardPkg::mulBusy) && (mulAge == `HAZ_MUL_CYCLES + 1);
        anyStall = loadUse || branchStall || startNow ||
                   ((modelState == hazardPkg::mulBusy) && !expPv);
        expPipe.stallF = anyStall;
        expPipe.stallD = anyStall;
        expPipe.flushE = anyStall;

        checkCount += 3;
        assert (fwdCtrl == expFwd)
            else reportMismatch("fwdCtrl", 64'(fwdCtrl), 64'(expFwd));
        assert (pipeCtrl == expPipe)
            else reportMismatch("pipeCtrl", 64'(pipeCtrl), 64'(expPipe));
        assert (productValid == expPv)
            else reportMismatch("productValid", 64'(productValid), 64'(expPv));

        // DUT stall cycles from the start through the product cycle
        if (startNow)
            stallRun = 0;
        if ((startNow || (modelState == hazardPkg::mulBusy)) && pipeCtrl.stallF)
            stallRun++;
        if (productValid)
            pulseCount++;

        if (expPv)
        begin
            checkCount += 2;
            assert (product == expProduct)
                else reportMismatch("product", product, expProduct);
            assert (stallRun == `HAZ_MUL_CYCLES + 1)
                else reportMismatch("multiply stall length", 64'(stallRun),
                                    64'(`HAZ_MUL_CYCLES + 1));
            lastProduct = expProduct;
            haveProduct = 1'b1;
        end
        else if (haveProduct && (modelState == hazardPkg::mulIdle))
        begin
            checkCount++;
            assert (product == lastProduct)
                else reportMismatch("held product", product, lastProduct);
        end

        // State as it will be after the coming edge
        if (startNow)
        begin
            modelState = hazardPkg::mulBusy;
            mulAge     = 1;
            expProduct = hazardPkg::productT'(mulA) * hazardPkg::productT'(mulB);
            startCount++;
        end
        else if (expPv)
            modelState = hazardPkg::mulIdle;
        else if (modelState == hazardPkg::mulBusy)
            mulAge++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic applyCycle(input int mode);
        @(posedge clk);
        #1;
        driveStages(mode);
        @(negedge clk);                 // Outputs settled mid-cycle
        checkCycle();
    endtask

    task automatic runTest(input string name, input int mode, input int vectors);
        int errBefore;
        errBefore = errCount;
        repeat (vectors)
            applyCycle(mode);
        testCount++;
        $display("Test %-10s %0d vectors, %0d errors", name, vectors, errCount - errBefore);
    endtask

    task automatic drainMultiply();
        int errBefore;
        int vectors;
        errBefore = errCount;
        vectors   = 0;
        while (modelState == hazardPkg::mulBusy)
        begin
            applyCycle(ModeDrain);
            vectors++;
        end
        checkCount++;
        assert (pulseCount == startCount)
            else reportMismatch("productValid pulse count", 64'(pulseCount), 64'(startCount));
        testCount++;
        $display("Test %-10s %0d vectors, %0d errors", "mulDrain", vectors,
                 errCount - errBefore);
    endtask

    initial
    begin
        arstN       = 1'b0;
        decStage    = '0;
        exeStage    = '0;
        memStage    = '0;
        wbStage     = '0;
        mulA        = '0;
        mulB        = '0;
        modelState  = hazardPkg::mulIdle;
        mulAge      = 0;
        expProduct  = '0;
        lastProduct = '0;
        haveProduct = 1'b0;
        stallRun    = 0;
        startCount  = 0;
        pulseCount  = 0;
        errCount    = 0;
        checkCount  = 0;
        testCount   = 0;
        cycleCount  = 0;
        void'($urandom(16));

        repeat (ResetCycles) @(posedge clk);
        #1;
        arstN = 1'b1;
        @(negedge clk);
        checkCycle();                   // Idle with no hazards on all-zero stages
        testCount++;
        $display("Test %-10s %0d vectors, %0d errors", "reset", 1, errCount);

        runTest("forward", ModeFwd, FwdVectors);
        runTest("loadUse", ModeLoad, LoadVectors);
        runTest("branch", ModeBranch, BrVectors);
        runTest("multiply", ModeMul, MulVectors);
        drainMultiply();

        $display("Summary: %0d tests, %0d checks, %0d errors, %0d multiplies",
                 testCount, checkCount, errCount, startCount);
        if (errCount == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
logic/hazardPkg.sv
logic/forwardUnit.sv
logic/stallUnit.sv
logic/seqMultiplier.sv
logic/hazardTop.sv
bench/tbHazard.sv

// ==== run.sh ====
#!/bin/sh
# Build the hazard block testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module tbHazard -Mdir obj_dir -f flist.f

status=0
./obj_dir/VtbHazard > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "Simulation passed"
exit 0
